// File: src/frame_pkg.sv
package frame_pkg;

  localparam int DATA_W  = 64;
  localparam int TS_W    = 48;
  localparam int TS_LO_W = 32;
  localparam int ADC_W   = 12;
  localparam int CH_ID_W = 4;
  localparam int FLEN_W  = 12;
  localparam int HOLD_W  = 8;

  localparam logic [15:0] HDR_ID = 16'hAAAA;
  localparam logic [15:0] FTR_ID = 16'h5555;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [TS_W-1:0]   timestamp;
    logic [ADC_W-1:0]  baseline;
    logic [ADC_W:0]    threshold;
  } adc_sample_t;

  typedef struct packed {
    logic [15:0]         hdr_id;
    logic [CH_ID_W-1:0]  ch_id;
    logic [TS_LO_W-1:0]  ts_lo;
    logic [FLEN_W-1:0]   frame_len;
  } frame_header_t;

  typedef struct packed {
    logic [15:0] baseline;
    logic [15:0] threshold;
    logic [15:0] ts_hi;
    logic [15:0] ftr_id;
  } frame_footer_t;

  // one info fifo entry
  typedef struct packed {
    frame_footer_t footer;
    frame_header_t header;
  } frame_info_t;

  // output word as seen on the stream
  typedef union packed {
    frame_header_t     hdr;
    frame_footer_t     ftr;
    logic [DATA_W-1:0] raw;
  } frame_word_u;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic               enable;
    logic [CH_ID_W-1:0] ch_id;
    logic [HOLD_W-1:0]  hold_len;
  } frame_cfg_t;

endpackage

// File: src/trigger_extender.sv
`timescale 1ns/1ns
module trigger_extender import frame_pkg::*; (
  input  logic       RD_CLK,
  input  logic       WR_RESET,
  input  logic       trigger,
  input  frame_cfg_t cfg,
  output logic       rec_en
);

  logic [HOLD_W-1:0] hold_cnt;
  logic              trig_gated;

  assign trig_gated = trigger && cfg.enable;

  // window stays open while trigger is high or hold counter is running
  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      hold_cnt <= '0;
      rec_en   <= 1'b0;
    end else begin
      rec_en <= trig_gated || (hold_cnt != '0);
      if (trig_gated) begin
        // hold length taken fresh at every trigger
        hold_cnt <= cfg.hold_len;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
    end
  end

endmodule

// File: src/frame_writer.sv
`timescale 1ns/1ns
module frame_writer import frame_pkg::*; #(
  parameter int MAX_FRAME_LEN = 16,
  parameter int DATA_DEPTH    = 64,
  parameter int INFO_DEPTH    = 8
) (
  input  logic                             RD_CLK,
  input  logic                             WR_RESET,
  input  adc_sample_t                      sample,
  input  logic                             rec_en,
  input  logic [CH_ID_W-1:0]               ch_id,
  output logic                             data_push,
  output logic [DATA_W-1:0]                data_wdata,
  input  logic [$clog2(DATA_DEPTH+1)-1:0]  data_free,
  output logic                             info_push,
  output frame_info_t                      info_wdata,
  input  logic [$clog2(INFO_DEPTH+1)-1:0]  info_free,
  output logic                             frame_done,
  output logic                             frame_drop
);

  localparam int CNT_W = $clog2(MAX_FRAME_LEN + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(MAX_FRAME_LEN);

  adc_sample_t       sample_q;
  logic [CNT_W-1:0]  cnt;
  logic              keep;
  frame_header_t     hdr;
  frame_footer_t     ftr;
  frame_header_t     hdr_out;
  logic              first;
  logic              close;
  logic              room;
  int                data_avail;
  int                info_pending;

  // sample_q lines up with rec_en
  always_ff @(posedge RD_CLK) begin
    sample_q <= sample;
  end

  always_comb begin
    first = rec_en && (cnt == '0 || cnt == FULL_CNT);
    close = (cnt != '0) && (!rec_en || cnt == FULL_CNT);
    // the push in flight and a pending info entry are not yet in the fifo counts
    data_avail   = int'(data_free) - int'(data_push);
    info_pending = int'(info_push) + int'(close && keep);
    room = (data_avail >= MAX_FRAME_LEN) && (int'(info_free) > info_pending);
    hdr_out = hdr;
    hdr_out.frame_len = FLEN_W'(cnt);
  end

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      cnt        <= '0;
      keep       <= 1'b0;
      data_push  <= 1'b0;
      info_push  <= 1'b0;
      frame_drop <= 1'b0;
    end else begin
      if (rec_en) begin
        cnt <= first ? CNT_W'(1) : cnt + 1'b1;
      end else begin
        cnt <= '0;
      end
      if (first) begin
        keep <= room;
      end
      data_push  <= rec_en && (first ? room : keep);
      info_push  <= close && keep;
      frame_drop <= first && !room;
    end
  end

  assign frame_done = info_push;

  always_ff @(posedge RD_CLK) begin
    data_wdata <= sample_q.data;
    // header and footer fields come from the first sample
    if (first) begin
      hdr.hdr_id     <= HDR_ID;
      hdr.ch_id      <= ch_id;
      hdr.ts_lo      <= sample_q.timestamp[TS_LO_W-1:0];
      hdr.frame_len  <= '0;
      ftr.baseline   <= {{(16-ADC_W){sample_q.baseline[ADC_W-1]}}, sample_q.baseline};
      ftr.threshold  <= {{(15-ADC_W){sample_q.threshold[ADC_W]}}, sample_q.threshold};
      ftr.ts_hi      <= sample_q.timestamp[TS_W-1:TS_LO_W];
      ftr.ftr_id     <= FTR_ID;
    end
    // old frame closes on the same edge a new one may open
    if (close) begin
      info_wdata.header <= hdr_out;
      info_wdata.footer <= ftr;
    end
  end

  a_frame_len: assert property (@(posedge RD_CLK) disable iff (WR_RESET)
    cnt <= FULL_CNT)
    else $error("frame length count exceeds MAX_FRAME_LEN");

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/1ns
module sync_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 64
) (
  input  logic                         RD_CLK,
  input  logic                         WR_RESET,
  input  logic                         push,
  input  logic [WIDTH-1:0]             wdata,
  input  logic                         pop,
  output logic [WIDTH-1:0]             rdata,
  output logic                         empty,
  output logic                         full,
  output logic [$clog2(DEPTH+1)-1:0]   free
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wptr;
  logic [AW-1:0]    rptr;
  logic [CW-1:0]    count;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge RD_CLK) begin
    if (push) begin
      mem[wptr] <= wdata;
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= next_ptr(wptr);
      end
      if (pop) begin
        rptr <= next_ptr(rptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // first word falls through
  assign rdata = mem[rptr];
  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));
  assign free  = CW'(DEPTH) - count;

  a_no_overflow: assert property (@(posedge RD_CLK) disable iff (WR_RESET) push |-> !full)
    else $error("push into full fifo");
  a_no_underflow: assert property (@(posedge RD_CLK) disable iff (WR_RESET) pop |-> !empty)
    else $error("pop from empty fifo");

endmodule

// File: src/frame_reader.sv
`timescale 1ns/1ns
module frame_reader import frame_pkg::*; (
  input  logic              RD_CLK,
  input  logic              WR_RESET,
  input  frame_info_t       info_rdata,
  input  logic              info_empty,
  output logic              info_pop,
  input  logic [DATA_W-1:0] data_rdata,
  output logic              data_pop,
  output frame_word_u       m_data,
  output logic              m_valid,
  output logic              m_last,
  input  logic              m_ready
);

  // state names the word held in the output register
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_HEADER = 2'd1;
  localparam logic [1:0] ST_DATA   = 2'd2;
  localparam logic [1:0] ST_FOOTER = 2'd3;

  logic [1:0]        state;
  logic [FLEN_W-1:0] word_cnt;
  logic              advance;
  logic              last_data;

  // output register is free or being emptied this cycle
  assign advance   = !m_valid || m_ready;
  assign last_data = (word_cnt == info_rdata.header.frame_len);

  assign data_pop = advance && (state == ST_HEADER || (state == ST_DATA && !last_data));
  // entry is released once its footer is loaded, next header is then visible
  assign info_pop = advance && (state == ST_DATA) && last_data;

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      state    <= ST_IDLE;
      m_valid  <= 1'b0;
      m_last   <= 1'b0;
      word_cnt <= '0;
    end else if (advance) begin
      case (state)
        ST_IDLE, ST_FOOTER: begin
          if (!info_empty) begin
            m_data.hdr <= info_rdata.header;
            m_valid    <= 1'b1;
            m_last     <= 1'b0;
            state      <= ST_HEADER;
          end else begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
            state   <= ST_IDLE;
          end
        end
        ST_HEADER: begin
          // a frame always has at least one data word
          m_data.raw <= data_rdata;
          word_cnt   <= FLEN_W'(1);
          state      <= ST_DATA;
        end
        default: begin
          if (last_data) begin
            m_data.ftr <= info_rdata.footer;
            m_last     <= 1'b1;
            state      <= ST_FOOTER;
          end else begin
            m_data.raw <= data_rdata;
            word_cnt   <= word_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  a_hold_stall: assert property (@(posedge RD_CLK) disable iff (WR_RESET)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
    else $error("output word changed while stalled");

endmodule

// File: src/frame_cfg_apb.sv
`timescale 1ns/1ns
module frame_cfg_apb import frame_pkg::*; (
  input  logic       RD_CLK,
  input  logic       WR_RESET,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  output frame_cfg_t cfg,
  input  logic       frame_done,
  input  logic       frame_drop
);

  localparam logic [7:0] ADDR_CTRL   = 8'h00;
  localparam logic [7:0] ADDR_HOLD   = 8'h04;
  localparam logic [7:0] ADDR_STATUS = 8'h08;

  logic [15:0] done_cnt;
  logic [15:0] drop_cnt;
  logic        access;
  logic        addr_ok;

  assign access  = apb_req.psel && apb_req.penable;
  assign addr_ok = apb_req.paddr inside {ADDR_CTRL, ADDR_HOLD, ADDR_STATUS};

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      cfg      <= '0;
      done_cnt <= '0;
      drop_cnt <= '0;
    end else begin
      if (access && apb_req.pwrite) begin
        case (apb_req.paddr)
          ADDR_CTRL: begin
            cfg.enable <= apb_req.pwdata[0];
            cfg.ch_id  <= apb_req.pwdata[4 +: CH_ID_W];
          end
          ADDR_HOLD: cfg.hold_len <= apb_req.pwdata[HOLD_W-1:0];
          // status is read only
          default: ;
        endcase
      end
      // counters wrap
      if (frame_done) begin
        done_cnt <= done_cnt + 1'b1;
      end
      if (frame_drop) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && !addr_ok;
    case (apb_req.paddr)
      ADDR_CTRL:   apb_rsp.prdata = {24'd0, cfg.ch_id, 3'd0, cfg.enable};
      ADDR_HOLD:   apb_rsp.prdata = {{(32-HOLD_W){1'b0}}, cfg.hold_len};
      ADDR_STATUS: apb_rsp.prdata = {drop_cnt, done_cnt};
      default:     apb_rsp.prdata = '0;
    endcase
  end

endmodule

// File: src/frame_gen_top.sv
`timescale 1ns/1ns
module frame_gen_top import frame_pkg::*; #(
  parameter int MAX_FRAME_LEN = 16,
  parameter int DATA_DEPTH    = 64,
  parameter int INFO_DEPTH    = 8
) (
  input  logic        RD_CLK,
  input  logic        WR_RESET,
  input  adc_sample_t sample,
  input  logic        trigger,
  output frame_word_u m_data,
  output logic        m_valid,
  output logic        m_last,
  input  logic        m_ready,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp
);

  localparam int DFREE_W = $clog2(DATA_DEPTH + 1);
  localparam int IFREE_W = $clog2(INFO_DEPTH + 1);

  frame_cfg_t         cfg;
  logic               rec_en;
  logic               data_push;
  logic               data_pop;
  logic [DATA_W-1:0]  data_wdata;
  logic [DATA_W-1:0]  data_rdata;
  logic [DFREE_W-1:0] data_free;
  logic               info_push;
  logic               info_pop;
  logic               info_empty;
  logic [IFREE_W-1:0] info_free;
  frame_info_t        info_wdata;
  frame_info_t        info_rdata;
  logic               frame_done;
  logic               frame_drop;

  frame_cfg_apb u_cfg (
    .RD_CLK(RD_CLK), .WR_RESET(WR_RESET), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .cfg(cfg), .frame_done(frame_done), .frame_drop(frame_drop)
  );

  trigger_extender u_ext (
    .RD_CLK(RD_CLK), .WR_RESET(WR_RESET), .trigger(trigger), .cfg(cfg), .rec_en(rec_en)
  );

  frame_writer #(
    .MAX_FRAME_LEN(MAX_FRAME_LEN), .DATA_DEPTH(DATA_DEPTH), .INFO_DEPTH(INFO_DEPTH)
  ) u_writer (
    .RD_CLK(RD_CLK), .WR_RESET(WR_RESET), .sample(sample), .rec_en(rec_en),
    .ch_id(cfg.ch_id), .data_push(data_push), .data_wdata(data_wdata),
    .data_free(data_free), .info_push(info_push), .info_wdata(info_wdata),
    .info_free(info_free), .frame_done(frame_done), .frame_drop(frame_drop)
  );

  sync_fifo #(.WIDTH(DATA_W), .DEPTH(DATA_DEPTH)) data_fifo (
    .RD_CLK(RD_CLK), .WR_RESET(WR_RESET), .push(data_push), .wdata(data_wdata),
    .pop(data_pop), .rdata(data_rdata), .empty(), .full(), .free(data_free)
  );

  sync_fifo #(.WIDTH($bits(frame_info_t)), .DEPTH(INFO_DEPTH)) info_fifo (
    .RD_CLK(RD_CLK), .WR_RESET(WR_RESET), .push(info_push), .wdata(info_wdata),
    .pop(info_pop), .rdata(info_rdata), .empty(info_empty), .full(), .free(info_free)
  );

  frame_reader u_reader (
    .RD_CLK(RD_CLK), .WR_RESET(WR_RESET), .info_rdata(info_rdata),
    .info_empty(info_empty), .info_pop(info_pop), .data_rdata(data_rdata),
    .data_pop(data_pop), .m_data(m_data), .m_valid(m_valid), .m_last(m_last),
    .m_ready(m_ready)
  );

endmodule

// File: verification/frame_gen_tb.sv
`timescale 1ns/1ns
module frame_gen_tb import frame_pkg::*; ();

  localparam int MAX_LEN  = 16;
  localparam int IDLE     = 20;
  localparam int T3_TRIG  = 40;
  localparam int T3_OFF   = 10;
  localparam int T4_RUNS  = 8;
  localparam int T4_MAX   = 20;
  localparam int T4_GAP   = 30;
  localparam int T5_RUNS  = 10;
  localparam int T5_TRIG  = 20;
  localparam int T5_GAP   = 5;
  localparam int STIM_CYCLES = 16 + 40 + (2 + IDLE) + (T3_TRIG + T3_OFF + 2 * IDLE + 20)
                               + T4_RUNS * (T4_MAX + T4_GAP) + T5_RUNS * (T5_TRIG + T5_GAP) + 100;
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 2000;

  typedef struct packed {
    logic               trig;
    logic               en;
    logic [CH_ID_W-1:0] ch_id;
    logic [HOLD_W-1:0]  hold;
    adc_sample_t        smp;
  } hist_t;

  logic        RD_CLK;
  logic        WR_RESET;
  adc_sample_t sample;
  logic        trigger;
  frame_word_u m_data;
  logic        m_valid;
  logic        m_last;
  logic        m_ready;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;

  hist_t              hist[$];
  int                 f_start[$];
  int                 f_len[$];
  string              test_name;
  logic               cur_en;
  logic [CH_ID_W-1:0] cur_ch;
  logic [HOLD_W-1:0]  cur_hold;
  logic [TS_W-1:0]    ts_count;
  int                 ready_mode;
  logic               drop_mode;
  int                 mf;
  int                 pos;
  int                 delivered;
  int                 cycles = 0;

  frame_gen_top #(.MAX_FRAME_LEN(MAX_LEN), .DATA_DEPTH(64), .INFO_DEPTH(8)) dut (
    .RD_CLK(RD_CLK), .WR_RESET(WR_RESET), .sample(sample), .trigger(trigger),
    .m_data(m_data), .m_valid(m_valid), .m_last(m_last), .m_ready(m_ready),
    .apb_req(apb_req), .apb_rsp(apb_rsp)
  );

  initial begin
    RD_CLK = 1'b0;
    forever #10 RD_CLK = ~RD_CLK;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, expected, actual);
      stop_run("value mismatch");
    end
  endtask

  // recording window and frame split over the whole history
  function automatic void build_frames();
    int   cnt;
    int   len;
    logic rec;
    cnt = 0;
    len = 0;
    f_start.delete();
    f_len.delete();
    foreach (hist[c]) begin
      if (hist[c].trig && hist[c].en) begin
        rec = 1'b1;
        cnt = hist[c].hold;
      end else if (cnt > 0) begin
        rec = 1'b1;
        cnt--;
      end else begin
        rec = 1'b0;
      end
      if (len > 0 && (!rec || len == MAX_LEN)) begin
        f_len.push_back(len);
        len = 0;
      end
      if (rec) begin
        if (len == 0) begin
          f_start.push_back(c);
        end
        len++;
      end
    end
  endfunction

  // word p of model frame k with header first and footer last
  function automatic frame_word_u expected_word(input int k, input int p);
    frame_word_u w;
    hist_t       h;
    h = hist[f_start[k]];
    if (p == 0) begin
      w.hdr.hdr_id    = HDR_ID;
      w.hdr.ch_id     = h.ch_id;
      w.hdr.ts_lo     = h.smp.timestamp[31:0];
      w.hdr.frame_len = FLEN_W'(f_len[k]);
    end else if (p > f_len[k]) begin
      w.ftr.baseline  = {{4{h.smp.baseline[11]}}, h.smp.baseline};
      w.ftr.threshold = {{3{h.smp.threshold[12]}}, h.smp.threshold};
      w.ftr.ts_hi     = h.smp.timestamp[47:32];
      w.ftr.ftr_id    = FTR_ID;
    end else begin
      w.raw = hist[f_start[k] + p - 1].smp.data;
    end
    return w;
  endfunction

  task automatic apb_access(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge RD_CLK);
    apb_req.paddr   = addr;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge RD_CLK);
    apb_req.penable = 1'b1;
    @(posedge RD_CLK);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_value("pready", 1, apb_rsp.pready);
    @(negedge RD_CLK);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_ctrl(input logic en);
    logic [31:0] rd;
    logic        err;
    apb_access(8'h00, 1'b1, {24'd0, cur_ch, 3'd0, en}, rd, err);
    cur_en = en;
  endtask

  task automatic write_hold(input logic [HOLD_W-1:0] h);
    logic [31:0] rd;
    logic        err;
    apb_access(8'h04, 1'b1, 32'(h), rd, err);
    cur_hold = h;
  endtask

  task automatic read_status(output logic [15:0] written, output logic [15:0] dropped);
    logic [31:0] rd;
    logic        err;
    apb_access(8'h08, 1'b0, 32'd0, rd, err);
    written = rd[15:0];
    dropped = rd[31:16];
  endtask

  task automatic pulse_trigger(input int high_cycles, input int low_cycles);
    @(negedge RD_CLK);
    trigger = 1'b1;
    repeat (high_cycles) @(negedge RD_CLK);
    trigger = 1'b0;
    repeat (low_cycles) @(negedge RD_CLK);
  endtask

  task automatic wait_frames(input int n);
    while (delivered < n) @(negedge RD_CLK);
  endtask

  // new sample every cycle with a running timestamp
  always @(negedge RD_CLK) begin
    sample.data      = {$urandom, $urandom};
    sample.timestamp = ts_count;
    sample.baseline  = ADC_W'($urandom);
    sample.threshold = (ADC_W + 1)'($urandom);
    ts_count         = ts_count + 1'b1;
    case (ready_mode)
      0:       m_ready = 1'b1;
      1:       m_ready = ($urandom % 4) != 0;
      default: m_ready = 1'b0;
    endcase
  end

  always @(posedge RD_CLK) begin : monitor
    hist_t h;
    int    k;
    if (!WR_RESET) begin
      h.trig  = trigger;
      h.en    = cur_en;
      h.ch_id = cur_ch;
      h.hold  = cur_hold;
      h.smp   = sample;
      hist.push_back(h);
      if (m_valid && m_ready) begin
        if (pos == 0) begin
          build_frames();
          k = mf;
          // skip over dropped frames
          while (drop_mode && k < f_len.size() && expected_word(k, 0) !== m_data) begin
            k++;
          end
          if (k >= f_len.size()) begin
            stop_run("a frame arrived that the model does not expect");
          end
          mf = k;
        end
        check_value("word", expected_word(mf, pos), m_data);
        check_value("last flag", 64'(pos == f_len[mf] + 1), 64'(m_last));
        if (pos == f_len[mf] + 1) begin
          pos = 0;
          mf++;
          delivered++;
        end else begin
          pos++;
        end
      end
    end
  end

  always @(posedge RD_CLK) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      stop_run("timeout: the DUT did not deliver all frames within the cycle limit");
    end
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [15:0] written;
    logic [15:0] dropped;
    int          n;
    void'($urandom(80519));
    WR_RESET   = 1'b1;
    trigger    = 1'b0;
    sample     = '0;
    m_ready    = 1'b0;
    apb_req    = '0;
    ts_count   = 48'hA5C3_FFFF_F000;
    ready_mode = 0;
    drop_mode  = 1'b0;
    mf         = 0;
    pos        = 0;
    delivered  = 0;
    cur_en     = 1'b0;
    cur_ch     = '0;
    cur_hold   = '0;
    test_name  = "reset";
    repeat (16) @(posedge RD_CLK);
    @(negedge RD_CLK);
    WR_RESET = 1'b0;

    test_name = "apb_access";
    apb_access(8'h00, 1'b1, 32'h0000_00A0, rd, err);
    check_value("ctrl write error", 0, err);
    apb_access(8'h00, 1'b0, 32'd0, rd, err);
    check_value("ctrl readback", 32'hA0, rd);
    apb_access(8'h04, 1'b1, 32'h0000_0003, rd, err);
    apb_access(8'h04, 1'b0, 32'd0, rd, err);
    check_value("hold readback", 32'h3, rd);
    apb_access(8'h08, 1'b1, 32'hFFFF_FFFF, rd, err);
    check_value("status write error", 0, err);
    apb_access(8'h08, 1'b0, 32'd0, rd, err);
    check_value("status readback", 0, rd);
    apb_access(8'h0C, 1'b0, 32'd0, rd, err);
    check_value("bad address error", 1, err);
    cur_ch   = 4'hA;
    cur_hold = 8'd3;

    test_name = "single_trigger";
    write_ctrl(1'b1);
    pulse_trigger(2, IDLE);
    build_frames();
    wait_frames(f_len.size());
    read_status(written, dropped);
    check_value("frame count", 1, written);

    test_name = "long_trigger";
    write_hold(8'd2);
    pulse_trigger(T3_TRIG, IDLE);
    // gated off, nothing may be recorded
    write_ctrl(1'b0);
    pulse_trigger(T3_OFF, IDLE);
    write_ctrl(1'b1);
    build_frames();
    wait_frames(f_len.size());
    read_status(written, dropped);
    check_value("frame count", 4, written);

    test_name = "random_stall";
    ready_mode = 1;
    repeat (T4_RUNS) pulse_trigger(1 + $urandom % T4_MAX, T4_GAP);
    build_frames();
    wait_frames(f_len.size());
    read_status(written, dropped);
    check_value("dropped frames", 0, dropped);

    test_name = "overflow_drop";
    ready_mode = 2;
    drop_mode  = 1'b1;
    repeat (T5_RUNS) pulse_trigger(T5_TRIG, T5_GAP);
    build_frames();
    n = f_len.size();
    ready_mode = 0;
    do begin
      read_status(written, dropped);
    end while (int'(written) + int'(dropped) != n);
    wait_frames(written);
    read_status(written, dropped);
    check_value("written vs delivered", 64'(written), 64'(delivered));
    check_value("written plus dropped", 64'(n), 64'(int'(written) + int'(dropped)));
    check_value("drops seen", 1, 64'(dropped != 0));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: all.f
src/frame_pkg.sv
src/trigger_extender.sv
src/frame_writer.sv
src/sync_fifo.sv
src/frame_reader.sv
src/frame_cfg_apb.sv
src/frame_gen_top.sv
verification/frame_gen_tb.sv
